// File: hw/node_pkg.sv
package node_pkg;

	// ==================================================
	// Bus geometry
	// ==================================================

	localparam int DATA_W = 32;	// Width of every data bus in the node
	localparam int SEL_W = DATA_W / 8;	// One lane select per byte of data

	// ==================================================
	// Address map
	// ==================================================

	// Region codes live in address bits 31..18
	localparam logic [13:0] REGION_MAIN = 14'd0;	// Shared main RAM
	localparam logic [13:0] REGION_SCRATCH = 14'd1;	// Private CPU scratchpad

	// Word address widths of the two memories
	localparam int MAIN_AW = 10;	// 1024 words
	localparam int SCRATCH_AW = 8;	// 256 words

	// Edges from an accepted access to its acknowledge
	localparam int RD_LATENCY = 2;

	// ==================================================
	// Address word
	// ==================================================

	// The same 32 bits are seen either as a flat word or split into fields
	// The decoder looks at the region and the memory ports take the word index
	typedef union packed {
		logic [31:0] word;	// Address as the master drives it
		struct packed {
			logic [13:0] region;	// Picks main RAM, scratchpad or nothing
			logic [15:0] index;	// Word index inside the region
			logic [1:0] offset;	// Byte offset, covered by the lane selects
		} part;
	} bus_addr_u;

endpackage

// File: hw/block_ram.sv
`timescale 1ns/1ns

module block_ram #(
	parameter int ADDR_W = node_pkg::SCRATCH_AW
) (
	input logic clk_i,
	input logic rst_i,
	input logic en_i,
	input logic [node_pkg::SEL_W-1:0] we_i,
	input logic [ADDR_W-1:0] adr_i,
	input logic [node_pkg::DATA_W-1:0] dat_i,
	output logic [node_pkg::DATA_W-1:0] dat_o,
	output logic ack_o
);
	import node_pkg::*;

	logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];	// Inferred word array
	logic [DATA_W-1:0] rd_q;	// First read stage, straight off the array
	logic [DATA_W-1:0] dat_q;	// Second read stage, drives dat_o
	logic [RD_LATENCY:0] ack_sr;	// One bit per cycle of the access in flight
	logic busy;
	logic start;	// Access accepted on this edge

	// Busy runs from the accept edge through the ack cycle
	// A master still holding its request after ack is not served twice
	assign busy = |ack_sr;
	assign start = en_i & ~busy;

	// ==================================================
	// Array and read pipeline
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (start) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (we_i[b]) begin
					mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];	// Only selected lanes change
				end
			end
			rd_q <= mem[adr_i];	// Read-first, a write returns the old word
		end
		if (ack_sr[0]) begin
			dat_q <= rd_q;	// Held until the next access passes through
		end
	end

	// Acknowledge generator
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_sr <= '0;
		end else begin
			ack_sr <= {ack_sr[RD_LATENCY-1:0], start};
		end
	end

	assign ack_o = ack_sr[RD_LATENCY];	// RD_LATENCY edges after the accept edge
	assign dat_o = dat_q;

endmodule

// File: hw/node_decode.sv
`timescale 1ns/1ns

module node_decode (
	input logic clk_i,
	input logic rst_i,
	input logic cpu_cyc_i,
	input logic cpu_stb_i,
	input node_pkg::bus_addr_u cpu_adr_i,
	output logic main_stb_o,
	output logic scratch_stb_o,
	input logic main_ack_i,
	input logic scratch_ack_i,
	input logic [node_pkg::DATA_W-1:0] main_dat_i,
	input logic [node_pkg::DATA_W-1:0] scratch_dat_i,
	output logic [node_pkg::DATA_W-1:0] cpu_dat_o,
	output logic cpu_ack_o,
	output logic cpu_err_o
);
	import node_pkg::*;

	logic cpu_req;	// CPU has a live strobe this cycle
	logic hit_main;
	logic hit_scratch;
	logic miss_req;	// Live strobe to a region nobody answers
	logic err_q;	// One-cycle error pulse
	logic err_done_q;	// Error already given for the request still held

	assign cpu_req = cpu_cyc_i & cpu_stb_i;
	assign hit_main = (cpu_adr_i.part.region == REGION_MAIN);
	assign hit_scratch = (cpu_adr_i.part.region == REGION_SCRATCH);

	// Mapped regions pass straight through with no added delay
	assign main_stb_o = cpu_req & hit_main;
	assign scratch_stb_o = cpu_req & hit_scratch;
	assign miss_req = cpu_req & ~hit_main & ~hit_scratch;

	// Unmapped access gets err one cycle after it is first seen
	// The done flag stops a second pulse while the master still holds stb
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			err_q <= 1'b0;
			err_done_q <= 1'b0;
		end else begin
			err_q <= miss_req & ~err_q & ~err_done_q;
			err_done_q <= miss_req & (err_q | err_done_q);	// Clears once stb drops
		end
	end

	// Read data follows the region of the address the CPU is holding
	always_comb begin
		case (cpu_adr_i.part.region)
			REGION_MAIN: cpu_dat_o = main_dat_i;
			REGION_SCRATCH: cpu_dat_o = scratch_dat_i;
			default: cpu_dat_o = '0;	// Nothing drives data for a miss
		endcase
	end

	assign cpu_ack_o = main_ack_i | scratch_ack_i;	// Only one slave can be selected
	assign cpu_err_o = err_q;

endmodule

// File: hw/node_arbiter.sv
`timescale 1ns/1ns

module node_arbiter (
	input logic clk_i,
	input logic rst_i,
	input logic cpu_req_i,
	input logic cpu_we_i,
	input logic [node_pkg::SEL_W-1:0] cpu_sel_i,
	input node_pkg::bus_addr_u cpu_adr_i,
	input logic [node_pkg::DATA_W-1:0] cpu_dat_i,
	output logic cpu_ack_o,
	output logic [node_pkg::DATA_W-1:0] cpu_dat_o,
	input logic net_req_i,
	input logic net_we_i,
	input logic [node_pkg::SEL_W-1:0] net_sel_i,
	input node_pkg::bus_addr_u net_adr_i,
	input logic [node_pkg::DATA_W-1:0] net_dat_i,
	output logic net_ack_o,
	output logic [node_pkg::DATA_W-1:0] net_dat_o,
	output logic ram_en_o,
	output logic [node_pkg::SEL_W-1:0] ram_we_o,
	output logic [node_pkg::MAIN_AW-1:0] ram_adr_o,
	output logic [node_pkg::DATA_W-1:0] ram_dat_o,
	input logic [node_pkg::DATA_W-1:0] ram_dat_i,
	input logic ram_ack_i
);
	import node_pkg::*;

	logic gnt_q;	// A master owns the RAM port
	logic owner_q;	// Owning master is the network side when high
	logic prio_q;	// Network side wins the next tie when high
	logic pick_net;	// Winner if a grant is taken this edge

	assign pick_net = net_req_i & (~cpu_req_i | prio_q);

	// ==================================================
	// Grant
	// ==================================================

	// Grant is held until the RAM acknowledges however long that takes
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			gnt_q <= 1'b0;
			owner_q <= 1'b0;
			prio_q <= 1'b0;	// CPU wins the first tie
		end else if (gnt_q) begin
			if (ram_ack_i) begin
				gnt_q <= 1'b0;	// Released at the end of the ack cycle
			end
		end else if (cpu_req_i | net_req_i) begin
			gnt_q <= 1'b1;
			owner_q <= pick_net;
			if (cpu_req_i & net_req_i) begin
				prio_q <= ~pick_net;	// Loser of a tie goes first at the next tie
			end
		end
	end

	// ==================================================
	// Request and response steering
	// ==================================================

	// RAM ignores a held request while its own access is in flight
	assign ram_en_o = gnt_q & (owner_q ? net_req_i : cpu_req_i);
	assign ram_we_o = owner_q ? (net_sel_i & {SEL_W{net_we_i}}) :
		(cpu_sel_i & {SEL_W{cpu_we_i}});
	assign ram_adr_o = owner_q ? net_adr_i.part.index[MAIN_AW-1:0] :
		cpu_adr_i.part.index[MAIN_AW-1:0];
	assign ram_dat_o = owner_q ? net_dat_i : cpu_dat_i;

	// Acknowledge and data go to the owner only
	assign cpu_ack_o = gnt_q & ~owner_q & ram_ack_i;
	assign net_ack_o = gnt_q & owner_q & ram_ack_i;
	assign cpu_dat_o = owner_q ? '0 : ram_dat_i;
	assign net_dat_o = owner_q ? ram_dat_i : '0;

endmodule

// File: hw/node_top.sv
`timescale 1ns/1ns

module node_top (
	input logic clk_i,
	input logic rst_i,
	input logic cpu_cyc_i,
	input logic cpu_stb_i,
	input logic cpu_we_i,
	input logic [node_pkg::SEL_W-1:0] cpu_sel_i,
	input node_pkg::bus_addr_u cpu_adr_i,
	input logic [node_pkg::DATA_W-1:0] cpu_dat_i,
	output logic [node_pkg::DATA_W-1:0] cpu_dat_o,
	output logic cpu_ack_o,
	output logic cpu_err_o,
	input logic net_cyc_i,
	input logic net_stb_i,
	input logic net_we_i,
	input logic [node_pkg::SEL_W-1:0] net_sel_i,
	input node_pkg::bus_addr_u net_adr_i,
	input logic [node_pkg::DATA_W-1:0] net_dat_i,
	output logic [node_pkg::DATA_W-1:0] net_dat_o,
	output logic net_ack_o
);
	import node_pkg::*;

	// CPU side after the region decode
	logic main_stb;
	logic scratch_stb;
	logic main_ack;	// Main RAM ack routed to the CPU
	logic [DATA_W-1:0] main_dat;
	logic scratch_ack;
	logic [DATA_W-1:0] scratch_dat;

	// Arbitrated main RAM port
	logic ram_en;
	logic [SEL_W-1:0] ram_we;
	logic [MAIN_AW-1:0] ram_adr;
	logic [DATA_W-1:0] ram_wdat;
	logic [DATA_W-1:0] ram_rdat;
	logic ram_ack;

	node_decode u_decode (.clk_i, .rst_i, .cpu_cyc_i, .cpu_stb_i, .cpu_adr_i,
		.main_stb_o(main_stb), .scratch_stb_o(scratch_stb), .main_ack_i(main_ack),
		.scratch_ack_i(scratch_ack), .main_dat_i(main_dat), .scratch_dat_i(scratch_dat),
		.cpu_dat_o, .cpu_ack_o, .cpu_err_o);

	// Network side request is its cyc and stb together
	node_arbiter u_arbiter (.clk_i, .rst_i, .cpu_req_i(main_stb), .cpu_we_i, .cpu_sel_i,
		.cpu_adr_i, .cpu_dat_i, .cpu_ack_o(main_ack), .cpu_dat_o(main_dat),
		.net_req_i(net_cyc_i & net_stb_i), .net_we_i, .net_sel_i, .net_adr_i, .net_dat_i,
		.net_ack_o, .net_dat_o, .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_adr_o(ram_adr),
		.ram_dat_o(ram_wdat), .ram_dat_i(ram_rdat), .ram_ack_i(ram_ack));

	// ==================================================
	// Memories
	// ==================================================

	block_ram #(.ADDR_W(MAIN_AW)) u_main (.clk_i, .rst_i, .en_i(ram_en), .we_i(ram_we),
		.adr_i(ram_adr), .dat_i(ram_wdat), .dat_o(ram_rdat), .ack_o(ram_ack));

	// Scratchpad belongs to the CPU alone so it needs no arbiter
	block_ram #(.ADDR_W(SCRATCH_AW)) u_scratch (.clk_i, .rst_i, .en_i(scratch_stb),
		.we_i(cpu_sel_i & {SEL_W{cpu_we_i}}), .adr_i(cpu_adr_i.part.index[SCRATCH_AW-1:0]),
		.dat_i(cpu_dat_i), .dat_o(scratch_dat), .ack_o(scratch_ack));

endmodule

// File: tests/node_assertions.sv
`timescale 1ns/1ns

module node_assertions (
	input logic clk_i,
	input logic rst_i,
	input logic cpu_cyc_i,
	input logic cpu_stb_i,
	input logic cpu_ack_o,
	input logic cpu_err_o,
	input logic net_cyc_i,
	input logic net_stb_i,
	input logic net_ack_o
);
	int fail_count = 0;	// Failed assertions so far

	// A slave ends an access with ack or err but never both
	ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(cpu_ack_o && cpu_err_o)) else begin
		fail_count++;
		$error("cpu ack and err high in the same cycle");
	end

	// ==================================================
	// Single-cycle acknowledge
	// ==================================================

	cpu_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		cpu_ack_o |=> !cpu_ack_o) else begin
		fail_count++;
		$error("cpu ack held longer than one cycle");
	end

	net_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		net_ack_o |=> !net_ack_o) else begin
		fail_count++;
		$error("net ack held longer than one cycle");
	end

	// The master still holds cyc and stb in the ack cycle
	cpu_ack_req: assert property (@(posedge clk_i) disable iff (rst_i)
		cpu_ack_o |-> (cpu_cyc_i && cpu_stb_i)) else begin
		fail_count++;
		$error("cpu ack without a request held");
	end

	net_ack_req: assert property (@(posedge clk_i) disable iff (rst_i)
		net_ack_o |-> (net_cyc_i && net_stb_i)) else begin
		fail_count++;
		$error("net ack without a request held");
	end

endmodule

bind node_top node_assertions u_assertions (.clk_i, .rst_i, .cpu_cyc_i, .cpu_stb_i, .cpu_ack_o,
	.cpu_err_o, .net_cyc_i, .net_stb_i, .net_ack_o);

// File: tests/node_tb.sv
`timescale 1ns/1ns

module node_tb;
	import node_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 5;	// Inputs change this long after the rising edge
	localparam int RESET_CYCLES = 8;
	localparam int ACCESS_LIMIT = 16;	// Cycles a master waits for ack or err
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_NS = NUM_TESTS * 200 * CLK_PERIOD;

	logic clk_i;
	logic rst_i;
	logic cpu_cyc_i;
	logic cpu_stb_i;
	logic cpu_we_i;
	logic [SEL_W-1:0] cpu_sel_i;
	bus_addr_u cpu_adr_i;
	logic [DATA_W-1:0] cpu_dat_i;
	logic [DATA_W-1:0] cpu_dat_o;
	logic cpu_ack_o;
	logic cpu_err_o;
	logic net_cyc_i;
	logic net_stb_i;
	logic net_we_i;
	logic [SEL_W-1:0] net_sel_i;
	bus_addr_u net_adr_i;
	logic [DATA_W-1:0] net_dat_i;
	logic [DATA_W-1:0] net_dat_o;
	logic net_ack_o;

	int data_errors = 0;
	int flag_errors = 0;
	int timing_errors = 0;
	int other_errors = 0;
	logic [31:0] rng_state = 32'hbf6f2c6a;
	logic [DATA_W-1:0] main_model [0:(1 << MAIN_AW) - 1];	// Expected main RAM contents
	logic [DATA_W-1:0] scratch_model [0:(1 << SCRATCH_AW) - 1];
	logic [15:0] idx [0:3] = '{16'h0003, 16'h0010, 16'h00a5, 16'h00ff};	// Fit both memories

	node_top u_dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// ==================================================
	// Helpers
	// ==================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [DATA_W-1:0] next_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Byte lanes with sel high take the new byte, the others keep the old one
	function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_w,
			input logic [DATA_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] w;
		w = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				w[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return w;
	endfunction

	function automatic bus_addr_u make_addr(input logic [13:0] region, input logic [15:0] index);
		bus_addr_u a;
		a.part.region = region;
		a.part.index = index;
		a.part.offset = 2'b00;	// Word aligned, lanes come from sel
		return a;
	endfunction

	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			data_errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errors++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_edges(input string name, input int exp, input int act);
		if (act != exp) begin
			timing_errors++;
			$display("error %s: expected %0d edges, actual %0d", name, exp, act);
		end
	endtask

	// ==================================================
	// Bus masters
	// ==================================================

	// Holds the request until ack or err, samples outputs on the falling edge
	task automatic cpu_access(input logic we, input logic [SEL_W-1:0] sel, input bus_addr_u adr,
			input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat, output logic ack,
			output logic err, output int edges);
		@(posedge clk_i);
		#DRIVE_DLY;
		cpu_cyc_i = 1'b1;
		cpu_stb_i = 1'b1;
		cpu_we_i = we;
		cpu_sel_i = sel;
		cpu_adr_i = adr;
		cpu_dat_i = wdat;
		ack = 1'b0;
		err = 1'b0;
		rdat = '0;
		edges = 0;
		while (!ack && !err && edges < ACCESS_LIMIT) begin
			@(posedge clk_i);
			edges++;	// Edges seen since the request went out
			@(negedge clk_i);
			ack = cpu_ack_o;
			err = cpu_err_o;
			rdat = cpu_dat_o;
		end
		if (!ack && !err) begin
			other_errors++;
			$display("cpu access to %h got neither ack nor err in time", adr.word);
		end
		@(posedge clk_i);
		#DRIVE_DLY;
		cpu_cyc_i = 1'b0;	// Request drops in the cycle after the ack
		cpu_stb_i = 1'b0;
		cpu_we_i = 1'b0;
	endtask

	task automatic net_access(input logic we, input logic [SEL_W-1:0] sel, input bus_addr_u adr,
			input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat, output logic ack);
		int edges;
		@(posedge clk_i);
		#DRIVE_DLY;
		net_cyc_i = 1'b1;
		net_stb_i = 1'b1;
		net_we_i = we;
		net_sel_i = sel;
		net_adr_i = adr;
		net_dat_i = wdat;
		ack = 1'b0;
		rdat = '0;
		edges = 0;
		while (!ack && edges < ACCESS_LIMIT) begin
			@(posedge clk_i);
			edges++;
			@(negedge clk_i);
			ack = net_ack_o;
			rdat = net_dat_o;
		end
		if (!ack) begin
			other_errors++;
			$display("net access to %h got no ack in time", adr.word);
		end
		@(posedge clk_i);
		#DRIVE_DLY;
		net_cyc_i = 1'b0;
		net_stb_i = 1'b0;
		net_we_i = 1'b0;
	endtask

	task automatic cpu_write(input string name, input bus_addr_u adr,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] rd;
		logic ack;
		logic err;
		int n;
		cpu_access(1'b1, sel, adr, data, rd, ack, err, n);
		check_flag(name, 1'b1, ack);
		check_flag(name, 1'b0, err);
	endtask

	task automatic cpu_read(input string name, input bus_addr_u adr, input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] rd;
		logic ack;
		logic err;
		int n;
		cpu_access(1'b0, 4'hf, adr, '0, rd, ack, err, n);
		check_flag(name, 1'b1, ack);
		check_flag(name, 1'b0, err);
		check_data(name, exp, rd);
	endtask

	task automatic net_write(input string name, input bus_addr_u adr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] rd;
		logic ack;
		net_access(1'b1, 4'hf, adr, data, rd, ack);
		check_flag(name, 1'b1, ack);
	endtask

	task automatic net_read(input string name, input bus_addr_u adr, input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] rd;
		logic ack;
		net_access(1'b0, 4'hf, adr, '0, rd, ack);
		check_flag(name, 1'b1, ack);
		check_data(name, exp, rd);
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic idle_flags(input string name);
		@(negedge clk_i);
		check_flag(name, 1'b0, cpu_ack_o);
		check_flag(name, 1'b0, cpu_err_o);
		check_flag(name, 1'b0, net_ack_o);
	endtask

	task automatic reset_values();
		repeat (RESET_CYCLES) idle_flags("reset");
		@(posedge clk_i);
		#DRIVE_DLY;
		rst_i = 1'b0;
		repeat (2) idle_flags("after_reset");
	endtask

	task automatic main_ram_rw();
		logic [DATA_W-1:0] w;
		foreach (idx[i]) begin
			w = next_word();
			cpu_write("main_ram", make_addr(REGION_MAIN, idx[i]), 4'hf, w);
			main_model[idx[i][MAIN_AW-1:0]] = w;
		end
		w = next_word();	// Lanes 1 and 3 must keep the bytes written above
		cpu_write("main_ram", make_addr(REGION_MAIN, idx[1]), 4'b0101, w);
		main_model[idx[1][MAIN_AW-1:0]] = merge_lanes(main_model[idx[1][MAIN_AW-1:0]], w, 4'b0101);
		foreach (idx[i]) cpu_read("main_ram", make_addr(REGION_MAIN, idx[i]),
			main_model[idx[i][MAIN_AW-1:0]]);
	endtask

	task automatic scratchpad_rw();
		logic [DATA_W-1:0] w;
		logic [DATA_W-1:0] rd;
		logic ack;
		logic err;
		int n;
		foreach (idx[i]) begin
			w = next_word();
			cpu_access(1'b1, 4'hf, make_addr(REGION_SCRATCH, idx[i]), w, rd, ack, err, n);
			check_flag("scratchpad", 1'b1, ack);
			check_edges("scratchpad", RD_LATENCY + 1, n);	// No arbiter in the path
			scratch_model[idx[i][SCRATCH_AW-1:0]] = w;
		end
		// Same word indices, the two memories stay apart
		foreach (idx[i]) begin
			cpu_read("scratchpad", make_addr(REGION_SCRATCH, idx[i]),
				scratch_model[idx[i][SCRATCH_AW-1:0]]);
			cpu_read("scratchpad", make_addr(REGION_MAIN, idx[i]), main_model[idx[i][MAIN_AW-1:0]]);
		end
	endtask

	task automatic unmapped_err();
		logic [DATA_W-1:0] rd;
		logic ack;
		logic err;
		int n;
		cpu_access(1'b1, 4'hf, make_addr(14'd2, idx[0]), next_word(), rd, ack, err, n);
		check_flag("unmapped", 1'b1, err);
		check_flag("unmapped", 1'b0, ack);
		check_edges("unmapped", 1, n);
		cpu_read("unmapped", make_addr(REGION_MAIN, idx[0]), main_model[idx[0][MAIN_AW-1:0]]);
		cpu_read("unmapped", make_addr(REGION_SCRATCH, idx[0]),
			scratch_model[idx[0][SCRATCH_AW-1:0]]);
	endtask

	task automatic shared_access();
		logic [DATA_W-1:0] w;
		w = next_word();
		net_write("sharing", make_addr(REGION_MAIN, 16'h0200), w);
		cpu_read("sharing", make_addr(REGION_MAIN, 16'h0200), w);
		w = next_word();
		cpu_write("sharing", make_addr(REGION_MAIN, 16'h0201), 4'hf, w);
		net_read("sharing", make_addr(REGION_MAIN, 16'h0201), w);
	endtask

	task automatic contention();
		logic [DATA_W-1:0] cw;
		logic [DATA_W-1:0] nw;
		for (int r = 0; r < 4; r++) begin
			cw = next_word();
			nw = next_word();
			fork	// Both requests go out on the same edge
				cpu_write("contention", make_addr(REGION_MAIN, 16'h0300 + 16'(r)), 4'hf, cw);
				net_write("contention", make_addr(REGION_MAIN, 16'h0380 + 16'(r)), nw);
			join
			// Each master reads back the word the other one wrote
			fork
				cpu_read("contention", make_addr(REGION_MAIN, 16'h0380 + 16'(r)), nw);
				net_read("contention", make_addr(REGION_MAIN, 16'h0300 + 16'(r)), cw);
			join
		end
	endtask

	initial begin
		int total;
		rst_i = 1'b1;
		cpu_cyc_i = 1'b0;
		cpu_stb_i = 1'b0;
		cpu_we_i = 1'b0;
		cpu_sel_i = '0;
		cpu_adr_i = '0;
		cpu_dat_i = '0;
		net_cyc_i = 1'b0;
		net_stb_i = 1'b0;
		net_we_i = 1'b0;
		net_sel_i = '0;
		net_adr_i = '0;
		net_dat_i = '0;
		reset_values();
		main_ram_rw();
		scratchpad_rw();
		unmapped_err();
		shared_access();
		contention();
		repeat (2) @(posedge clk_i);
		other_errors += u_dut.u_assertions.fail_count;
		total = data_errors + flag_errors + timing_errors + other_errors;
		$display("errors: data %0d, flag %0d, timing %0d, other %0d",
			data_errors, flag_errors, timing_errors, other_errors);
		if (total == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: list.f
hw/node_pkg.sv
hw/block_ram.sv
hw/node_decode.sv
hw/node_arbiter.sv
hw/node_top.sv
tests/node_assertions.sv
tests/node_tb.sv

// File: run.sh
#!/bin/sh
# Builds the node testbench with Verilator, runs it and checks the log.
# Exit status is 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=node_sim

verilator --binary --timing --assert -j 0 --top-module node_tb -f list.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
	echo "run passed"
	exit 0
else
	echo "run failed, see $LOG"
	exit 1
fi
